// ==== design/rvfi_trace_pkg.sv ====
// --------------------------------------------------------------------------
// Types shared by the RVFI tracer and its testbench
// XLEN is fixed at 32; no FP, vector or accelerator fields exist
// NR_SB_ENTRIES at the top must not exceed 2**TRANS_ID_BITS
// --------------------------------------------------------------------------
package rvfi_trace_pkg;

  // --------------------------------------------------------------------------
  // Widths
  // --------------------------------------------------------------------------
  localparam int unsigned XLEN = 32;
  localparam int unsigned XLEN_B = XLEN / 8;  // One mask bit per byte lane
  localparam int unsigned TRANS_ID_BITS = 3;  // 8 scoreboard slots

  // --------------------------------------------------------------------------
  // Encodings
  // --------------------------------------------------------------------------
  typedef enum logic [1:0] {
    FU_NONE, FU_LOAD, FU_STORE
  } fu_op_e;

  // Value 2 is left free, the record's mode field uses it for debug
  typedef enum logic [1:0] {
    PRIV_U = 2'd0, PRIV_S = 2'd1, PRIV_M = 2'd3
  } priv_lvl_e;

  typedef enum logic [4:0] {
    ILLEGAL_INSTR  = 5'd2,
    ENV_CALL_UMODE = 5'd8,
    ENV_CALL_SMODE = 5'd9,
    ENV_CALL_MMODE = 5'd11
  } exc_cause_e;

  // --------------------------------------------------------------------------
  // Probe bundles from the core pipeline
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic        fetch_entry_valid;
    logic [31:0] instruction;        // Raw word, low half only if compressed
    logic        is_compressed;
    logic        issue_instr_ack;
    logic        flush;
  } fetch_probe_t;

  typedef struct packed {
    logic                     decoded_instr_valid;
    logic                     decoded_instr_ack;
    logic                     flush_unissued_instr;
    logic [TRANS_ID_BITS-1:0] issue_pointer;
    logic [XLEN-1:0]          rs1_forwarding;
    logic [XLEN-1:0]          rs2_forwarding;
  } issue_probe_t;

  typedef struct packed {
    fu_op_e                   fu;
    logic [XLEN_B-1:0]        be;
    logic [XLEN-1:0]          vaddr;
    logic [TRANS_ID_BITS-1:0] trans_id;
    logic [XLEN-1:0]          wdata;
    logic [XLEN-1:0]          mem_paddr;  // Store path only
  } lsu_probe_t;

  // One commit port
  typedef struct packed {
    logic                     valid;
    logic                     commit_ack;
    logic [TRANS_ID_BITS-1:0] commit_pointer;
    logic [XLEN-1:0]          pc;
    logic [4:0]               rs1;
    logic [4:0]               rs2;
    logic [4:0]               rd;
    logic [XLEN-1:0]          result;     // Load data for memory ops
    logic [XLEN-1:0]          wdata;      // Register file write data
  } commit_probe_t;

  typedef struct packed {
    logic       valid;
    exc_cause_e cause;
  } exception_t;

  // --------------------------------------------------------------------------
  // Table rows and the retirement record
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic [31:0]     instr;
    logic [XLEN-1:0] rs1_rdata;
    logic [XLEN-1:0] rs2_rdata;
  } issue_rec_t;

  typedef struct packed {
    logic [XLEN-1:0]   addr;
    logic [XLEN_B-1:0] rmask;
    logic [XLEN_B-1:0] wmask;
    logic [XLEN-1:0]   wdata;
  } mem_rec_t;

  typedef struct packed {
    logic              valid;
    logic [31:0]       insn;
    logic              trap;
    exc_cause_e        cause;
    logic [1:0]        mode;
    logic [1:0]        ixl;
    logic [4:0]        rs1_addr;
    logic [4:0]        rs2_addr;
    logic [4:0]        rd_addr;
    logic [XLEN-1:0]   rd_wdata;
    logic [XLEN-1:0]   pc_rdata;
    logic [XLEN-1:0]   mem_addr;
    logic [XLEN-1:0]   mem_paddr;
    logic [XLEN_B-1:0] mem_rmask;
    logic [XLEN_B-1:0] mem_wmask;
    logic [XLEN-1:0]   mem_wdata;
    logic [XLEN-1:0]   mem_rdata;
    logic [XLEN-1:0]   rs1_rdata;
    logic [XLEN-1:0]   rs2_rdata;
  } rvfi_instr_t;

endpackage

// ==== design/rvfi_issue_capture.sv ====
`timescale 1ns/1ns
// --------------------------------------------------------------------------
// Instruction latch between decode and issue, plus the issue table
// The issue write takes the latched word whether or not the latch is valid
// Pointers at or above NR_SB_ENTRIES are ignored
// --------------------------------------------------------------------------
module rvfi_issue_capture
  import rvfi_trace_pkg::*;
#(
  parameter int unsigned NR_SB_ENTRIES = 8
) (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           clear_i,
  input  fetch_probe_t                   fetch_i,
  input  issue_probe_t                   issue_i,
  output issue_rec_t [NR_SB_ENTRIES-1:0] issue_tbl_o
);

  typedef struct packed {
    logic        valid;
    logic [31:0] instr;
  } instr_latch_t;

  instr_latch_t                   latch_q;
  instr_latch_t                   latch_d;
  logic [31:0]                    fetch_word;
  logic                           latch_load;
  logic                           issue_wr;
  issue_rec_t                     wr_row;
  issue_rec_t [NR_SB_ENTRIES-1:0] tbl_q;

  // --------------------------------------------------------------------------
  // Decode side latch
  // --------------------------------------------------------------------------
  // Compressed words keep only their low half
  assign fetch_word = fetch_i.is_compressed ? {16'h0000, fetch_i.instruction[15:0]}
                                            : fetch_i.instruction;

  // Accept when empty or when the held word leaves this cycle
  assign latch_load = fetch_i.fetch_entry_valid &&
                      (!latch_q.valid || fetch_i.issue_instr_ack);

  always_comb begin
    latch_d = latch_q;
    if (fetch_i.issue_instr_ack) begin
      latch_d.valid = 1'b0;
    end
    if (latch_load) begin
      latch_d.valid = 1'b1;
      latch_d.instr = fetch_word;
    end
    if (fetch_i.flush) begin
      latch_d.valid = 1'b0;  // Flush beats ack and fetch
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i || clear_i) begin
      latch_q <= '0;
    end else begin
      latch_q <= latch_d;
    end
  end

  // --------------------------------------------------------------------------
  // Issue table, one row per transaction id
  // --------------------------------------------------------------------------
  assign issue_wr = issue_i.decoded_instr_valid && issue_i.decoded_instr_ack &&
                    !issue_i.flush_unissued_instr;

  assign wr_row = '{
    instr:     latch_q.instr,
    rs1_rdata: issue_i.rs1_forwarding,
    rs2_rdata: issue_i.rs2_forwarding
  };

  always_ff @(posedge clk_i) begin
    if (rst_i || clear_i) begin
      tbl_q <= '0;
    end else begin
      for (int i = 0; i < NR_SB_ENTRIES; i++) begin
        if (issue_wr && (issue_i.issue_pointer == TRANS_ID_BITS'(i))) begin
          tbl_q[i] <= wr_row;  // Old row is simply overwritten
        end
      end
    end
  end

  assign issue_tbl_o = tbl_q;

endmodule

// ==== design/rvfi_mem_capture.sv ====
`timescale 1ns/1ns
// --------------------------------------------------------------------------
// Memory access table indexed by LSU transaction id
// An issue into a slot clears its memory fields; an LSU write in the same
// cycle to the same slot lands on top of that clear
// --------------------------------------------------------------------------
module rvfi_mem_capture
  import rvfi_trace_pkg::*;
#(
  parameter int unsigned NR_SB_ENTRIES = 8
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         clear_i,
  input  lsu_probe_t                   lsu_i,
  input  issue_probe_t                 issue_i,
  output mem_rec_t [NR_SB_ENTRIES-1:0] mem_tbl_o
);

  logic [XLEN_B-1:0]            rmask;
  logic [XLEN_B-1:0]            wmask;
  logic                         slot_reissue;
  mem_rec_t [NR_SB_ENTRIES-1:0] tbl_q;

  // Byte enables split by operation kind
  assign rmask = (lsu_i.fu == FU_LOAD) ? lsu_i.be : '0;
  assign wmask = (lsu_i.fu == FU_STORE) ? lsu_i.be : '0;

  // Same strobe that writes the issue table
  assign slot_reissue = issue_i.decoded_instr_valid && issue_i.decoded_instr_ack &&
                        !issue_i.flush_unissued_instr;

  always_ff @(posedge clk_i) begin
    if (rst_i || clear_i) begin
      tbl_q <= '0;
    end else begin
      for (int i = 0; i < NR_SB_ENTRIES; i++) begin
        if (slot_reissue && (issue_i.issue_pointer == TRANS_ID_BITS'(i))) begin
          tbl_q[i] <= '0;
        end
        if (lsu_i.trans_id == TRANS_ID_BITS'(i)) begin
          if (rmask != '0) begin
            // Load leaves the store fields as they are
            tbl_q[i].addr  <= lsu_i.vaddr;
            tbl_q[i].rmask <= rmask;
          end else if (wmask != '0) begin
            tbl_q[i].addr  <= lsu_i.vaddr;
            tbl_q[i].wmask <= wmask;
            tbl_q[i].wdata <= lsu_i.wdata;
          end
        end
      end
    end
  end

  assign mem_tbl_o = tbl_q;

endmodule

// ==== design/rvfi_commit_pack.sv ====
`timescale 1ns/1ns
// --------------------------------------------------------------------------
// Combinational packer, one RVFI record per commit port
// mem_paddr is the live LSU value, not a per-slot copy
// A pointer past NR_SB_ENTRIES reads an all-zero row
// --------------------------------------------------------------------------
module rvfi_commit_pack
  import rvfi_trace_pkg::*;
#(
  parameter int unsigned NR_COMMIT_PORTS = 2,
  parameter int unsigned NR_SB_ENTRIES   = 8,
  parameter bit          DEBUG_EN        = 1'b1
) (
  input  issue_rec_t    [NR_SB_ENTRIES-1:0]   issue_tbl_i,
  input  mem_rec_t      [NR_SB_ENTRIES-1:0]   mem_tbl_i,
  input  commit_probe_t [NR_COMMIT_PORTS-1:0] commit_i,
  input  exception_t                          ex_i,
  input  priv_lvl_e                           priv_lvl_i,
  input  logic                                debug_mode_i,
  input  logic          [XLEN-1:0]            mem_paddr_i,
  output rvfi_instr_t   [NR_COMMIT_PORTS-1:0] rvfi_o
);

  logic [1:0]                       mode;
  logic                             env_call;
  issue_rec_t [NR_COMMIT_PORTS-1:0] port_issue;
  mem_rec_t   [NR_COMMIT_PORTS-1:0] port_mem;
  logic       [NR_COMMIT_PORTS-1:0] port_trap;

  // --------------------------------------------------------------------------
  // Table lookup
  // --------------------------------------------------------------------------
  function automatic issue_rec_t issue_row(input issue_rec_t [NR_SB_ENTRIES-1:0] tbl,
                                           input logic [TRANS_ID_BITS-1:0] ptr);
    issue_rec_t row;
    row = '0;
    for (int i = 0; i < NR_SB_ENTRIES; i++) begin
      if (ptr == TRANS_ID_BITS'(i)) begin
        row = tbl[i];
      end
    end
    return row;
  endfunction

  function automatic mem_rec_t mem_row(input mem_rec_t [NR_SB_ENTRIES-1:0] tbl,
                                       input logic [TRANS_ID_BITS-1:0] ptr);
    mem_rec_t row;
    row = '0;
    for (int i = 0; i < NR_SB_ENTRIES; i++) begin
      if (ptr == TRANS_ID_BITS'(i)) begin
        row = tbl[i];
      end
    end
    return row;
  endfunction

  assign mode = (DEBUG_EN && debug_mode_i) ? 2'b10 : priv_lvl_i;  // 2 marks debug mode
  // Environment calls retire even though they trap
  assign env_call = ex_i.cause inside {ENV_CALL_UMODE, ENV_CALL_SMODE, ENV_CALL_MMODE};

  // --------------------------------------------------------------------------
  // Record assembly
  // --------------------------------------------------------------------------
  always_comb begin
    for (int p = 0; p < NR_COMMIT_PORTS; p++) begin
      port_issue[p] = issue_row(issue_tbl_i, commit_i[p].commit_pointer);
      port_mem[p]   = mem_row(mem_tbl_i, commit_i[p].commit_pointer);
      port_trap[p]  = commit_i[p].valid && ex_i.valid;

      rvfi_o[p].valid     = (commit_i[p].commit_ack && !ex_i.valid) ||
                            (port_trap[p] && env_call);
      rvfi_o[p].insn      = port_issue[p].instr;
      rvfi_o[p].trap      = port_trap[p];
      rvfi_o[p].cause     = ex_i.cause;
      rvfi_o[p].mode      = mode;
      rvfi_o[p].ixl       = 2'd1;              // RV32
      rvfi_o[p].rs1_addr  = commit_i[p].rs1;
      rvfi_o[p].rs2_addr  = commit_i[p].rs2;
      rvfi_o[p].rd_addr   = commit_i[p].rd;
      rvfi_o[p].rd_wdata  = commit_i[p].wdata;
      rvfi_o[p].pc_rdata  = commit_i[p].pc;
      rvfi_o[p].mem_addr  = port_mem[p].addr;
      rvfi_o[p].mem_paddr = mem_paddr_i;
      rvfi_o[p].mem_rmask = port_mem[p].rmask;
      rvfi_o[p].mem_wmask = port_mem[p].wmask;
      rvfi_o[p].mem_wdata = port_mem[p].wdata;
      rvfi_o[p].mem_rdata = commit_i[p].result;  // Load data rides on result
      rvfi_o[p].rs1_rdata = port_issue[p].rs1_rdata;
      rvfi_o[p].rs2_rdata = port_issue[p].rs2_rdata;
    end
  end

endmodule

// ==== design/rvfi_tracer.sv ====
`timescale 1ns/1ns
// --------------------------------------------------------------------------
// RVFI tracer top: issue and memory capture feeding the commit packer
// Issue to readable slot takes one cycle, commit to record takes none
// NR_SB_ENTRIES must not exceed 2**TRANS_ID_BITS; the core is never stalled
// --------------------------------------------------------------------------
module rvfi_tracer
  import rvfi_trace_pkg::*;
#(
  parameter int unsigned NR_COMMIT_PORTS = 2,  // 1 or 2
  parameter int unsigned NR_SB_ENTRIES   = 8,
  parameter bit          DEBUG_EN        = 1'b1
) (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic                                clear_i,
  input  fetch_probe_t                        fetch_i,
  input  issue_probe_t                        issue_i,
  input  lsu_probe_t                          lsu_i,
  input  commit_probe_t [NR_COMMIT_PORTS-1:0] commit_i,
  input  exception_t                          ex_i,
  input  priv_lvl_e                           priv_lvl_i,
  input  logic                                debug_mode_i,
  output rvfi_instr_t   [NR_COMMIT_PORTS-1:0] rvfi_o
);

  issue_rec_t [NR_SB_ENTRIES-1:0] issue_tbl;
  mem_rec_t   [NR_SB_ENTRIES-1:0] mem_tbl;

  rvfi_issue_capture #(
    .NR_SB_ENTRIES (NR_SB_ENTRIES)
  ) u_issue_capture (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .clear_i     (clear_i),
    .fetch_i     (fetch_i),
    .issue_i     (issue_i),
    .issue_tbl_o (issue_tbl)
  );

  // Issue strobe also resets the slot's memory fields
  rvfi_mem_capture #(
    .NR_SB_ENTRIES (NR_SB_ENTRIES)
  ) u_mem_capture (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .clear_i   (clear_i),
    .lsu_i     (lsu_i),
    .issue_i   (issue_i),
    .mem_tbl_o (mem_tbl)
  );

  rvfi_commit_pack #(
    .NR_COMMIT_PORTS (NR_COMMIT_PORTS),
    .NR_SB_ENTRIES   (NR_SB_ENTRIES),
    .DEBUG_EN        (DEBUG_EN)
  ) u_commit_pack (
    .issue_tbl_i  (issue_tbl),
    .mem_tbl_i    (mem_tbl),
    .commit_i     (commit_i),
    .ex_i         (ex_i),
    .priv_lvl_i   (priv_lvl_i),
    .debug_mode_i (debug_mode_i),
    .mem_paddr_i  (lsu_i.mem_paddr),  // Straight from the LSU probe
    .rvfi_o       (rvfi_o)
  );

endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ns
// --------------------------------------------------------------------------
// Free running testbench clock, starts low
// Reset is high for RST_CYCLES rising edges and drops on a falling edge
// --------------------------------------------------------------------------
module tb_clock_gen #(
  parameter int unsigned PERIOD     = 40,
  parameter int unsigned RST_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;  // Released on the stimulus edge
  end

endmodule

// ==== tb/rvfi_tracer_tb.sv ====
`timescale 1ns/1ns
// --------------------------------------------------------------------------
// Directed testbench for the RVFI tracer, the tasks play the part of the core
// Inputs change on the falling edge, records are read a quarter period later
// Two commit ports, debug mode reporting enabled, 8 scoreboard slots
// --------------------------------------------------------------------------
module rvfi_tracer_tb;
  import rvfi_trace_pkg::*;

  localparam int unsigned NR_PORTS    = 2;
  localparam int unsigned NR_SLOTS    = 8;
  localparam int unsigned CLK_PERIOD  = 40;
  localparam int unsigned TEST_CYCLES = 76;  // Sum over all tests, reset included

  logic                          clk;
  logic                          rst;
  logic                          clear;
  fetch_probe_t                  fetch;
  issue_probe_t                  issue;
  lsu_probe_t                    lsu;
  commit_probe_t [NR_PORTS-1:0]  commit;
  exception_t                    ex;
  priv_lvl_e                     priv_lvl;
  logic                          debug_mode;
  rvfi_instr_t   [NR_PORTS-1:0]  rvfi;

  // Reference copies of both tables
  issue_rec_t  model_issue [NR_SLOTS];
  mem_rec_t    model_mem   [NR_SLOTS];
  logic [31:0] rng_state;
  int          test_errs;
  int          total_errs;
  int          tests_run;
  int          tests_failed;

  tb_clock_gen #(.PERIOD(CLK_PERIOD), .RST_CYCLES(2)) u_clock_gen (.clk_o(clk), .rst_o(rst));

  rvfi_tracer #(
    .NR_COMMIT_PORTS (NR_PORTS),
    .NR_SB_ENTRIES   (NR_SLOTS),
    .DEBUG_EN        (1'b1)
  ) uut (
    .clk_i        (clk),
    .rst_i        (rst),
    .clear_i      (clear),
    .fetch_i      (fetch),
    .issue_i      (issue),
    .lsu_i        (lsu),
    .commit_i     (commit),
    .ex_i         (ex),
    .priv_lvl_i   (priv_lvl),
    .debug_mode_i (debug_mode),
    .rvfi_o       (rvfi)
  );

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic clear_model();
    for (int i = 0; i < NR_SLOTS; i++) begin
      model_issue[i] = '0;
      model_mem[i]   = '0;
    end
  endtask

  task automatic check_eq(input int port, input string what, input logic [31:0] got,
                          input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Error at %0t ns: port %0d %s is %h, expected %h", $time, port, what, got, exp);
      test_errs++;
    end
  endtask

  task automatic check_bit(input int port, input string what, input logic got, input logic exp);
    check_eq(port, what, 32'(got), 32'(exp));
  endtask

  task automatic end_test(input string name);
    tests_run++;
    total_errs += test_errs;
    if (test_errs != 0) begin
      tests_failed++;
    end
    $display("test %s: %s, %0d errors", name, (test_errs == 0) ? "passed" : "failed", test_errs);
    test_errs = 0;
  endtask

  // --------------------------------------------------------------------------
  // Core side drivers, each starts and ends on a falling edge
  // --------------------------------------------------------------------------
  task automatic issue_slot(input logic [2:0] ptr, input logic [31:0] word, input bit comp,
                            input bit drop);
    logic [31:0] op1;
    logic [31:0] op2;
    op1 = next_rand();
    op2 = next_rand();
    fetch.fetch_entry_valid = 1'b1;
    fetch.instruction       = word;
    fetch.is_compressed     = comp;
    fetch.issue_instr_ack   = 1'b1;  // Frees the latch so the word is taken
    @(negedge clk);
    fetch                       = '0;
    fetch.issue_instr_ack       = 1'b1;
    issue.decoded_instr_valid   = 1'b1;
    issue.decoded_instr_ack     = 1'b1;
    issue.flush_unissued_instr  = drop;
    issue.issue_pointer         = ptr;
    issue.rs1_forwarding        = op1;
    issue.rs2_forwarding        = op2;
    @(negedge clk);
    fetch = '0;
    issue = '0;
    if (!drop) begin
      model_issue[ptr].instr     = comp ? {16'h0000, word[15:0]} : word;
      model_issue[ptr].rs1_rdata = op1;
      model_issue[ptr].rs2_rdata = op2;
      model_mem[ptr]             = '0;  // Fresh issue has no memory access yet
    end
  endtask

  task automatic lsu_access(input logic [2:0] ptr, input bit store, input logic [3:0] be);
    lsu.fu       = store ? FU_STORE : FU_LOAD;
    lsu.be       = be;
    lsu.vaddr    = next_rand();
    lsu.trans_id = ptr;
    lsu.wdata    = next_rand();
    @(negedge clk);
    model_mem[ptr].addr = lsu.vaddr;
    if (store) begin
      model_mem[ptr].wmask = be;
      model_mem[ptr].wdata = lsu.wdata;
    end else begin
      model_mem[ptr].rmask = be;  // Store fields stay
    end
    lsu = '0;
  endtask

  // Commits port 0, and port 1 too when both is set, then checks the records
  task automatic commit_check(input logic [2:0] ptr0, input logic [2:0] ptr1, input bit both);
    logic [31:0] res  [NR_PORTS];
    logic [31:0] wd   [NR_PORTS];
    logic [31:0] pc   [NR_PORTS];
    logic [31:0] regs [NR_PORTS];
    logic [2:0]  ptr  [NR_PORTS];
    logic [31:0] paddr;
    ptr[0]        = ptr0;
    ptr[1]        = ptr1;
    paddr         = next_rand();
    lsu.mem_paddr = paddr;  // Live LSU value, shared by both ports
    for (int p = 0; p < NR_PORTS; p++) begin
      res[p]    = next_rand();
      wd[p]     = next_rand();
      pc[p]     = next_rand();
      regs[p]   = next_rand();
      commit[p] = '0;
      if (p == 0 || both) begin
        commit[p].valid          = 1'b1;
        commit[p].commit_ack     = 1'b1;
        commit[p].commit_pointer = ptr[p];
        commit[p].pc             = pc[p];
        commit[p].rs1            = regs[p][4:0];
        commit[p].rs2            = regs[p][9:5];
        commit[p].rd             = regs[p][14:10];
        commit[p].result         = res[p];
        commit[p].wdata          = wd[p];
      end
    end
    #(CLK_PERIOD / 4);
    for (int p = 0; p < NR_PORTS; p++) begin
      check_bit(p, "valid", rvfi[p].valid, (p == 0 || both));
      if (p == 0 || both) begin
        check_eq(p, "insn", rvfi[p].insn, model_issue[ptr[p]].instr);
        check_eq(p, "rs1_rdata", rvfi[p].rs1_rdata, model_issue[ptr[p]].rs1_rdata);
        check_eq(p, "rs2_rdata", rvfi[p].rs2_rdata, model_issue[ptr[p]].rs2_rdata);
        check_eq(p, "mem_addr", rvfi[p].mem_addr, model_mem[ptr[p]].addr);
        check_eq(p, "mem_rmask", 32'(rvfi[p].mem_rmask), 32'(model_mem[ptr[p]].rmask));
        check_eq(p, "mem_wmask", 32'(rvfi[p].mem_wmask), 32'(model_mem[ptr[p]].wmask));
        check_eq(p, "mem_wdata", rvfi[p].mem_wdata, model_mem[ptr[p]].wdata);
        check_eq(p, "mem_rdata", rvfi[p].mem_rdata, res[p]);
        check_eq(p, "mem_paddr", rvfi[p].mem_paddr, paddr);
        check_eq(p, "rd_wdata", rvfi[p].rd_wdata, wd[p]);
        check_eq(p, "pc_rdata", rvfi[p].pc_rdata, pc[p]);
        check_eq(p, "rs1_addr", 32'(rvfi[p].rs1_addr), 32'(regs[p][4:0]));
        check_eq(p, "rs2_addr", 32'(rvfi[p].rs2_addr), 32'(regs[p][9:5]));
        check_eq(p, "rd_addr", 32'(rvfi[p].rd_addr), 32'(regs[p][14:10]));
        check_eq(p, "ixl", 32'(rvfi[p].ixl), 32'd1);  // RV32
        check_bit(p, "trap", rvfi[p].trap, 1'b0);
      end
    end
    @(negedge clk);
    commit        = '0;
    lsu.mem_paddr = '0;
  endtask

  task automatic check_mode(input bit dbg, input priv_lvl_e lvl, input logic [1:0] exp);
    debug_mode = dbg;
    priv_lvl   = lvl;
    #(CLK_PERIOD / 4);
    for (int p = 0; p < NR_PORTS; p++) begin
      check_eq(p, "mode", 32'(rvfi[p].mode), 32'(exp));
    end
    @(negedge clk);
  endtask

  task automatic check_trap(input logic exp_valid, input logic exp_trap, input exc_cause_e cause);
    #(CLK_PERIOD / 4);
    check_bit(0, "valid", rvfi[0].valid, exp_valid);
    check_bit(0, "trap", rvfi[0].trap, exp_trap);
    check_eq(0, "cause", 32'(rvfi[0].cause), 32'(cause));
    check_bit(1, "valid", rvfi[1].valid, 1'b0);  // Idle port never traps
    check_bit(1, "trap", rvfi[1].trap, 1'b0);
    @(negedge clk);
  endtask

  // --------------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------------
  task automatic test_reset_clear();
    commit_check(3'd5, 3'd2, 1'b1);  // Nothing issued since reset
    issue_slot(3'd1, next_rand(), 1'b0, 1'b0);
    issue_slot(3'd5, next_rand(), 1'b0, 1'b0);
    lsu_access(3'd5, 1'b1, 4'hf);
    commit_check(3'd1, 3'd5, 1'b1);
    clear = 1'b1;
    @(negedge clk);
    clear = 1'b0;
    clear_model();
    commit_check(3'd1, 3'd5, 1'b1);
    end_test("reset_clear");
  endtask

  task automatic test_plain();
    for (int i = 0; i < 6; i++) begin
      issue_slot(3'(i), next_rand(), 1'b0, 1'b0);
      commit_check(3'(i), 3'd0, 1'b0);
    end
    issue_slot(3'd6, next_rand(), 1'b1, 1'b0);  // Compressed
    commit_check(3'd6, 3'd0, 1'b0);
    end_test("plain_issue");
  endtask

  task automatic test_mem();
    logic [31:0] r;
    logic [2:0]  slot;
    slot = 3'd0;
    for (int i = 0; i < 4; i++) begin
      r    = next_rand();
      slot = r[2:0];
      issue_slot(slot, next_rand(), 1'b0, 1'b0);
      lsu_access(slot, i[0], r[7:4] | 4'h1);  // Never an empty byte mask
      commit_check(slot, 3'd0, 1'b0);
    end
    // Re-issue drops the slot's memory record
    issue_slot(slot, next_rand(), 1'b0, 1'b0);
    commit_check(slot, 3'd0, 1'b0);
    end_test("mem_access");
  endtask

  task automatic test_exceptions();
    issue_slot(3'd3, next_rand(), 1'b0, 1'b0);
    commit[0].valid          = 1'b1;
    commit[0].commit_pointer = 3'd3;
    ex.valid                 = 1'b1;
    ex.cause                 = ENV_CALL_MMODE;
    check_trap(1'b1, 1'b1, ENV_CALL_MMODE);
    ex.cause = ILLEGAL_INSTR;
    check_trap(1'b0, 1'b1, ILLEGAL_INSTR);
    ex.valid = 1'b0;  // No ack and no exception
    check_trap(1'b0, 1'b0, ILLEGAL_INSTR);
    commit = '0;
    ex     = '0;
    end_test("exceptions");
  endtask

  task automatic test_flush();
    logic [31:0] word;
    issue_slot(3'd2, next_rand(), 1'b0, 1'b0);
    issue_slot(3'd2, next_rand(), 1'b0, 1'b1);  // Dropped write
    commit_check(3'd2, 3'd0, 1'b0);
    fetch.fetch_entry_valid = 1'b1;
    fetch.instruction       = next_rand();
    fetch.issue_instr_ack   = 1'b1;
    @(negedge clk);
    fetch       = '0;
    fetch.flush = 1'b1;
    @(negedge clk);
    word                    = next_rand();
    fetch                   = '0;
    fetch.fetch_entry_valid = 1'b1;  // No ack, only an empty latch takes it
    fetch.instruction       = word;
    @(negedge clk);
    fetch                     = '0;
    issue.decoded_instr_valid = 1'b1;
    issue.decoded_instr_ack   = 1'b1;
    issue.issue_pointer       = 3'd4;
    @(negedge clk);
    issue          = '0;
    model_issue[4] = '{instr: word, rs1_rdata: '0, rs2_rdata: '0};
    model_mem[4]   = '0;
    commit_check(3'd4, 3'd0, 1'b0);
    end_test("flush");
  endtask

  task automatic test_ports_mode();
    issue_slot(3'd0, next_rand(), 1'b0, 1'b0);
    issue_slot(3'd7, next_rand(), 1'b0, 1'b0);
    lsu_access(3'd7, 1'b0, 4'h3);
    commit_check(3'd0, 3'd7, 1'b1);
    check_mode(1'b1, PRIV_U, 2'd2);
    check_mode(1'b0, PRIV_S, 2'd1);
    check_mode(1'b0, PRIV_M, 2'd3);
    check_mode(1'b0, PRIV_U, 2'd0);
    priv_lvl = PRIV_M;
    end_test("ports_mode");
  endtask

  // --------------------------------------------------------------------------
  // Sequence and watchdog
  // --------------------------------------------------------------------------
  initial begin
    rng_state    = 32'd49;
    test_errs    = 0;
    total_errs   = 0;
    tests_run    = 0;
    tests_failed = 0;
    clear        = 1'b0;
    fetch        = '0;
    issue        = '0;
    lsu          = '0;
    commit       = '0;
    ex           = '0;
    priv_lvl     = PRIV_M;
    debug_mode   = 1'b0;
    clear_model();
    wait (rst === 1'b1);
    wait (rst === 1'b0);
    test_reset_clear();
    test_plain();
    test_mem();
    test_exceptions();
    test_flush();
    test_ports_mode();
    $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, total_errs);
    if (total_errs == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    #(TEST_CYCLES * 2 * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d cycles", TEST_CYCLES * 2);
    $display("** FAIL **");
    $finish;
  end

endmodule

// ==== sim.f ====
design/rvfi_trace_pkg.sv
design/rvfi_issue_capture.sv
design/rvfi_mem_capture.sv
design/rvfi_commit_pack.sv
design/rvfi_tracer.sv
tb/tb_clock_gen.sv
tb/rvfi_tracer_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the RVFI tracer testbench with Verilator and runs it
# Exit status is 0 only when the log holds the pass line

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
  -f sim.f --top-module rvfi_tracer_tb -Mdir "$BUILD_DIR" -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/tb_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qxF '** PASS **' "$LOG"; then
  exit 0
fi
echo "Pass line not found in $LOG"
exit 1
